// File: test/image_read_golden.txt
// one test per line: cfg_img_w cfg_img_dh cfg_pad cfg_conv ready_mode beats zero_beats lane0_sum
// ready_mode 0 keeps image_rdy_i high, 1 drives it at random; all values hex
00000003 00010002 00000000 00000000 0 18 00 0450
00000002 00000002 01010101 00020000 0 51 20 0310
00000004 00020004 00000000 00020001 0 6C 00 3E70
00000002 00000002 01010101 00020000 1 51 20 0310
00000001 00010001 02000001 00010000 1 30 1E 0114

// File: flist.f
design/img_read_pkg.sv
design/read_config.sv
design/window_scan.sv
design/addr_gen.sv
design/stream_fifo.sv
design/image_stream.sv
design/image_read.sv
test/image_read_checker.sv
test/image_read_assert.sv
test/image_read_tb.sv

// File: test/image_read_tb.sv
`timescale 1ns/1ps

module image_read_tb;
    import img_read_pkg::*;

    localparam int TEST_NB    = 5;
    localparam int GOLD_WORDS = 8;
    localparam int RST_CYCLES = 3;

    logic              clk;
    logic              rst;
    logic [CFG_DW-1:0] cfg_data_i;
    logic [CFG_AW-1:0] cfg_addr_i;
    logic              cfg_valid_i;
    logic              next_i;
    logic              rd_val_o;
    logic [MEM_AW-1:0] rd_addr_o;
    logic [BUS_W-1:0]  rd_data_i;
    logic [BUS_W-1:0]  image_bus_o;
    logic              image_val_o;
    logic              image_last_o;
    logic              image_rdy_i;

    logic [31:0] gold [TEST_NB*GOLD_WORDS];
    int          test_idx;
    int          exp_beats;
    int          exp_zero;
    int          exp_sum;
    logic        rand_rdy;
    int          tests_done;
    int          err_count;
    int          beat_cnt;
    int          cycle_cnt;
    int          cycle_limit;
    int          stray_err;
    int          assert_errs;
    int unsigned seed_val;

    logic              mem_val [RD_LATENCY];    // reads in flight
    logic [MEM_AW-1:0] mem_addr [RD_LATENCY];

    image_read image_read_inst (.*);

    image_read_checker checker_inst (
        .clk          (clk),
        .rst          (rst),
        .image_bus_i  (image_bus_o),
        .image_val_i  (image_val_o),
        .image_rdy_i  (image_rdy_i),
        .image_last_i (image_last_o),
        .test_idx     (test_idx),
        .exp_beats    (exp_beats),
        .exp_zero     (exp_zero),
        .exp_sum      (exp_sum),
        .tests_done   (tests_done),
        .err_count    (err_count),
        .beat_cnt     (beat_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [BUS_W-1:0] mem_word(input logic [MEM_AW-1:0] addr);
        logic [BUS_W-1:0] w;
        for (int k = 0; k < GROUP_NB; k++) w[k*PIXEL_W +: PIXEL_W] = PIXEL_W'(addr * 4 + k);
        return w;
    endfunction

    // memory answers RD_LATENCY cycles after the address
    always @(posedge clk) begin
        #1;
        rd_data_i = mem_val[RD_LATENCY-1] ? mem_word(mem_addr[RD_LATENCY-1]) : '0;
        for (int i = RD_LATENCY - 1; i > 0; i--) begin
            mem_val[i]  = mem_val[i-1];
            mem_addr[i] = mem_addr[i-1];
        end
        mem_val[0]  = rd_val_o;
        mem_addr[0] = rd_addr_o;
    end

    // ready pattern, repeatable from its seed
    initial begin
        seed_val = $urandom(36);
        forever begin
            @(posedge clk);
            #1;
            image_rdy_i = rand_rdy ? 1'($urandom % 2) : 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: scan did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic write_cfg(input logic [CFG_AW-1:0] addr, input logic [CFG_DW-1:0] data);
        @(posedge clk);
        #1;
        cfg_addr_i  = addr;
        cfg_data_i  = data;
        cfg_valid_i = 1'b1;
    endtask

    task automatic run_test(input int t);
        test_idx  = t;
        rand_rdy  = gold[t*GOLD_WORDS+4][0];
        exp_beats = int'(gold[t*GOLD_WORDS+5]);
        exp_zero  = int'(gold[t*GOLD_WORDS+6]);
        exp_sum   = int'(gold[t*GOLD_WORDS+7]);
        write_cfg(CFG_IMG_W, gold[t*GOLD_WORDS]);
        write_cfg(CFG_IMG_DH, gold[t*GOLD_WORDS+1]);
        write_cfg(CFG_PAD, gold[t*GOLD_WORDS+2]);
        write_cfg(CFG_CONV, gold[t*GOLD_WORDS+3]);
        @(posedge clk);
        #1;
        cfg_valid_i = 1'b0;
        next_i      = 1'b1;
        @(posedge clk);
        #1;
        next_i = 1'b0;
        while (tests_done < t + 1) @(posedge clk);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        cfg_data_i  = '0;
        cfg_addr_i  = '0;
        cfg_valid_i = 1'b0;
        next_i      = 1'b0;
        rd_data_i   = '0;
        image_rdy_i = 1'b1;
        rand_rdy    = 1'b0;
        test_idx    = 0;
        exp_beats   = 0;
        exp_zero    = 0;
        exp_sum     = 0;
        cycle_cnt   = 0;
        stray_err   = 0;
        assert_errs = 0;
        for (int i = 0; i < RD_LATENCY; i++) begin
            mem_val[i]  = 1'b0;
            mem_addr[i] = '0;
        end
        $readmemh("test/image_read_golden.txt", gold);
        cycle_limit = RST_CYCLES;
        for (int t = 0; t < TEST_NB; t++) cycle_limit += 4 * (int'(gold[t*GOLD_WORDS+5]) + 16);

        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int t = 0; t < TEST_NB; t++) run_test(t);

        rand_rdy = 1'b0;
        repeat (12) @(posedge clk);
        if (beat_cnt != 0) begin
            $display("extra beats arrived after the last beat of the final test");
            stray_err = 1;
        end
        assert_errs = image_read_inst.image_read_assert_inst.fail_cnt;
        $display("tests run %0d, errors %0d", tests_done, err_count + stray_err + assert_errs);
        if (err_count == 0 && stray_err == 0 && assert_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: test/image_read_assert.sv
`timescale 1ns/1ps

module image_read_assert (
    input logic                           clk,
    input logic                           rst,
    input logic                           rd_val_o,
    input logic [img_read_pkg::BUS_W-1:0] image_bus_o,
    input logic                           image_val_o,
    input logic                           image_last_o,
    input logic                           image_rdy_i
);
    import img_read_pkg::*;

    int fail_cnt;    // assertion failures so far

    initial fail_cnt = 0;

    // a stalled beat stays on the bus unchanged
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        (image_val_o && !image_rdy_i) |=>
            (image_val_o && $stable(image_bus_o) && $stable(image_last_o)))
        else begin
            $error("image beat changed while stalled");
            fail_cnt++;
        end

    // the final beat of a scan leaves nothing queued behind it
    last_final: assert property (@(posedge clk) disable iff (rst)
        (image_last_o && image_rdy_i) |=> !image_val_o)
        else begin
            $error("image beat followed the last beat of a scan");
            fail_cnt++;
        end

    reset_val: assert property (@(posedge clk) rst |=> (!image_val_o && !image_last_o))
        else begin
            $error("image_val_o high after reset");
            fail_cnt++;
        end

    // read pipeline is flushed by the time its idle positions arrive
    reset_rd: assert property (@(posedge clk) $fell(rst) |-> ##2 (rd_val_o == 1'b0))
        else begin
            $error("rd_val_o high after reset");
            fail_cnt++;
        end

endmodule

bind image_read image_read_assert image_read_assert_inst (
    .clk          (clk),
    .rst          (rst),
    .rd_val_o     (rd_val_o),
    .image_bus_o  (image_bus_o),
    .image_val_o  (image_val_o),
    .image_last_o (image_last_o),
    .image_rdy_i  (image_rdy_i)
);

// File: test/image_read_checker.sv
`timescale 1ns/1ps

module image_read_checker (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [img_read_pkg::BUS_W-1:0] image_bus_i,
    input  logic                           image_val_i,
    input  logic                           image_rdy_i,
    input  logic                           image_last_i,
    input  int                             test_idx,
    input  int                             exp_beats,
    input  int                             exp_zero,
    input  int                             exp_sum,
    output int                             tests_done,
    output int                             err_count,
    output int                             beat_cnt
);
    import img_read_pkg::*;

    int          zero_cnt;
    int          test_errs;
    logic [31:0] lane_sum;

    function automatic string test_name(input int idx);
        case (idx)
            0: return "no_pad_k1";
            1: return "pad_all_k3";
            2: return "k3_step2_d3";
            3: return "pad_all_k3_rand_rdy";
            default: return "asym_pad_k2_rand_rdy";
        endcase
    endfunction

    task automatic compare_count(input string what, input int expv, input int actv);
        if (expv != actv) begin
            $display("[ERROR] test %s %s expected %0d actual %0d",
                     test_name(test_idx), what, expv, actv);
            test_errs++;
        end
    endtask

    // non-padding beats carry lane k = lane 0 + k
    task automatic check_lanes(input logic [BUS_W-1:0] bus);
        logic [PIXEL_W-1:0] lane0;
        lane0 = bus[PIXEL_W-1:0];
        for (int k = 1; k < GROUP_NB; k++) begin
            if (bus[k*PIXEL_W +: PIXEL_W] != PIXEL_W'(lane0 + k)) begin
                $display("[ERROR] test %s lane %0d expected %0d actual %0d", test_name(test_idx),
                         k, PIXEL_W'(lane0 + k), bus[k*PIXEL_W +: PIXEL_W]);
                test_errs++;
            end
        end
    endtask

    initial begin
        tests_done = 0;
        err_count  = 0;
        beat_cnt   = 0;
        zero_cnt   = 0;
        test_errs  = 0;
        lane_sum   = '0;
    end

    // sampled mid cycle, a transfer happens on the next rising edge
    always @(negedge clk) begin
        if (!rst && image_val_i && image_rdy_i) begin
            beat_cnt++;
            if (image_bus_i == '0) zero_cnt++;
            else check_lanes(image_bus_i);
            lane_sum = lane_sum + image_bus_i[PIXEL_W-1:0];
            if (image_last_i) begin
                compare_count("beats", exp_beats, beat_cnt);
                compare_count("zero beats", exp_zero, zero_cnt);
                compare_count("lane0 sum", exp_sum, int'(lane_sum));
                if (test_errs == 0)
                    $display("test %s ok: %0d beats, %0d zero, sum %0d",
                             test_name(test_idx), beat_cnt, zero_cnt, lane_sum);
                else
                    $display("test %s done with %0d mismatches",
                             test_name(test_idx), test_errs);
                err_count  += test_errs;
                test_errs  = 0;
                beat_cnt   = 0;
                zero_cnt   = 0;
                lane_sum   = '0;
                tests_done++;
            end
        end
    end

endmodule

// File: design/image_read.sv
`timescale 1ns/1ps

module image_read (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [img_read_pkg::CFG_DW-1:0] cfg_data_i,
    input  logic [img_read_pkg::CFG_AW-1:0] cfg_addr_i,
    input  logic                            cfg_valid_i,
    input  logic                            next_i,      // load config and start a scan
    output logic                            rd_val_o,
    output logic [img_read_pkg::MEM_AW-1:0] rd_addr_o,
    input  logic [img_read_pkg::BUS_W-1:0]  rd_data_i,
    output logic [img_read_pkg::BUS_W-1:0]  image_bus_o,
    output logic                            image_val_o,
    output logic                            image_last_o,
    input  logic                            image_rdy_i
);
    import img_read_pkg::*;

    geom_t     geom;
    logic      geom_ready;
    scan_pos_t scan_pos;
    beat_tag_t tag;

    read_config read_config_inst (
        .clk          (clk),
        .cfg_data_i   (cfg_data_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_valid_i  (cfg_valid_i),
        .next_i       (next_i),
        .geom_o       (geom),
        .geom_ready_o (geom_ready)
    );

    window_scan window_scan_inst (
        .clk          (clk),
        .rst          (rst),
        .geom_i       (geom),
        .geom_ready_i (geom_ready),
        .image_rdy_i  (image_rdy_i),
        .pos_o        (scan_pos)
    );

    addr_gen addr_gen_inst (
        .clk       (clk),
        .geom_i    (geom),
        .pos_i     (scan_pos),
        .rd_val_o  (rd_val_o),
        .rd_addr_o (rd_addr_o),
        .tag_o     (tag)
    );

    image_stream image_stream_inst (
        .clk          (clk),
        .rst          (rst),
        .tag_i        (tag),
        .rd_data_i    (rd_data_i),
        .image_rdy_i  (image_rdy_i),
        .image_bus_o  (image_bus_o),
        .image_val_o  (image_val_o),
        .image_last_o (image_last_o)
    );

endmodule

// File: design/image_stream.sv
`timescale 1ns/1ps

module image_stream (
    input  logic                           clk,
    input  logic                           rst,
    input  img_read_pkg::beat_tag_t        tag_i,
    input  logic [img_read_pkg::BUS_W-1:0] rd_data_i,
    input  logic                           image_rdy_i,
    output logic [img_read_pkg::BUS_W-1:0] image_bus_o,
    output logic                           image_val_o,
    output logic                           image_last_o
);
    import img_read_pkg::*;

    beat_tag_t [RD_LATENCY-1:0] tag_p;
    beat_tag_t                  tag_rx;    // lines up with rd_data_i

    logic             beat_val;
    logic [BUS_W-1:0] beat_bus;
    logic             beat_last;

    logic [BUS_W:0]   head;
    logic             fifo_empty;
    logic             stall;

    assign tag_rx = tag_p[RD_LATENCY-1];

    always_ff @(posedge clk) begin
        if (rst) tag_p <= '0;
        else tag_p <= {tag_p[RD_LATENCY-2:0], tag_i};
    end

    always_ff @(posedge clk) begin
        if (rst) beat_val <= 1'b0;
        else beat_val <= tag_rx.read | tag_rx.pad;
    end

    always_ff @(posedge clk) begin
        beat_bus  <= tag_rx.read ? rd_data_i : '0;   // padding is a zero beat
        beat_last <= tag_rx.last;
    end

    stream_fifo fifo_inst (
        .clk         (clk),
        .rst         (rst),
        .push_i      (beat_val),
        .push_data_i ({beat_bus, beat_last}),
        .pop_i       (~stall),
        .pop_data_o  (head),
        .empty_o     (fifo_empty)
    );

    assign stall = image_val_o & ~image_rdy_i;

    always_ff @(posedge clk) begin
        if (rst) image_val_o <= 1'b0;
        else if (!stall) image_val_o <= ~fifo_empty;
    end

    assign image_bus_o  = head[BUS_W:1];
    assign image_last_o = image_val_o & head[0];

endmodule

// File: design/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push_i,
    input  logic [img_read_pkg::BUS_W:0] push_data_i,
    input  logic                         pop_i,
    output logic [img_read_pkg::BUS_W:0] pop_data_o,
    output logic                         empty_o
);
    import img_read_pkg::*;

    logic [BUS_W:0]   mem [2**FIFO_AW];
    logic [FIFO_AW:0] wr_ptr;          // extra bit tells full from empty
    logic [FIFO_AW:0] rd_ptr;
    logic             pop_ok;

    assign empty_o = (wr_ptr == rd_ptr);
    assign pop_ok  = pop_i & ~empty_o;

    always_ff @(posedge clk) begin
        if (push_i) mem[wr_ptr[FIFO_AW-1:0]] <= push_data_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // head is registered on pop and held otherwise
    always_ff @(posedge clk) begin
        if (pop_ok) pop_data_o <= mem[rd_ptr[FIFO_AW-1:0]];
    end

endmodule

// File: design/addr_gen.sv
`timescale 1ns/1ps

module addr_gen (
    input  logic                            clk,
    input  img_read_pkg::geom_t             geom_i,
    input  img_read_pkg::scan_pos_t         pos_i,
    output logic                            rd_val_o,
    output logic [img_read_pkg::MEM_AW-1:0] rd_addr_o,
    output img_read_pkg::beat_tag_t         tag_o
);
    import img_read_pkg::*;

    scan_pos_t          pos_1p;
    logic [COORD_W-1:0] rel_w;        // position relative to image origin
    logic [COORD_W-1:0] rel_h;
    logic               pad_hit;

    logic [LIN_W-1:0]   off_h_2p;
    logic [LIN_W-1:0]   off_w_2p;
    logic [COORD_W-1:0] d_2p;
    logic               val_2p;
    logic               pad_2p;
    logic               last_2p;

    logic [LIN_W-1:0]   sum_hw_3p;
    logic [COORD_W-1:0] d_3p;
    logic               val_3p;
    logic               pad_3p;
    logic               last_3p;

    assign rel_w = pos_1p.pos_w - geom_i.pad_l;
    assign rel_h = pos_1p.pos_h - geom_i.pad_t;

    assign pad_hit = (pos_1p.pos_w < geom_i.edge_l) | (pos_1p.pos_w > geom_i.edge_r)
                   | (pos_1p.pos_h < geom_i.edge_t) | (pos_1p.pos_h > geom_i.edge_b);

    always_ff @(posedge clk) begin
        pos_1p <= pos_i;

        val_2p   <= pos_1p.valid;
        pad_2p   <= pos_1p.valid & pad_hit;
        last_2p  <= pos_1p.last;
        off_h_2p <= LIN_W'(rel_h) * geom_i.plane_wxd;     // whole W*D planes above
        off_w_2p <= LIN_W'(rel_w) * LIN_W'(geom_i.img_d);
        d_2p     <= pos_1p.pos_d;
    end

    always_ff @(posedge clk) begin
        val_3p    <= val_2p;
        pad_3p    <= pad_2p;
        last_3p   <= last_2p;
        sum_hw_3p <= off_h_2p + off_w_2p;
        d_3p      <= d_2p;
    end

    // padding keeps its tag but issues no read
    always_ff @(posedge clk) begin
        tag_o.read <= val_3p & ~pad_3p;
        tag_o.pad  <= pad_3p;
        tag_o.last <= last_3p;
        rd_addr_o  <= MEM_AW'(sum_hw_3p + LIN_W'(d_3p));
    end

    assign rd_val_o = tag_o.read;

endmodule

// File: design/window_scan.sv
`timescale 1ns/1ps

module window_scan (
    input  logic                    clk,
    input  logic                    rst,
    input  img_read_pkg::geom_t     geom_i,
    input  logic                    geom_ready_i,
    input  logic                    image_rdy_i,
    output img_read_pkg::scan_pos_t pos_o
);
    import img_read_pkg::*;

    // one-hot state
    logic st_idle;
    logic st_run;
    logic st_pause;
    logic idle_nx;
    logic run_nx;
    logic pause_nx;

    logic [COORD_W-1:0] area_w_cnt;    // window origin
    logic [COORD_W-1:0] area_h_cnt;
    logic [COORD_W-1:0] kern_w_cnt;    // offset inside the window
    logic [COORD_W-1:0] kern_h_cnt;
    logic [COORD_W-1:0] kern_d_cnt;

    logic area_w_last;
    logic area_h_last;
    logic kern_w_last;
    logic kern_h_last;
    logic kern_d_last;
    logic kern_last;
    logic scan_last;

    // last origin when the next step would not fit a full window
    assign area_w_last = ({1'b0, area_w_cnt} + {1'b0, geom_i.conv_step})
                         > {1'b0, geom_i.area_w_max};
    assign area_h_last = ({1'b0, area_h_cnt} + {1'b0, geom_i.conv_step})
                         > {1'b0, geom_i.area_h_max};

    assign kern_w_last = (kern_w_cnt == geom_i.kern_max);
    assign kern_h_last = (kern_h_cnt == geom_i.kern_max);
    assign kern_d_last = (kern_d_cnt == geom_i.depth_max);
    assign kern_last   = kern_d_last & kern_w_last & kern_h_last;
    assign scan_last   = kern_last & area_w_last & area_h_last;

    always_comb begin
        idle_nx  = 1'b0;
        run_nx   = 1'b0;
        pause_nx = 1'b0;
        case (1'b1)
            st_idle: begin
                if (geom_ready_i & image_rdy_i) run_nx = 1'b1;
                else if (geom_ready_i) pause_nx = 1'b1;
                else idle_nx = 1'b1;
            end
            st_run: begin
                if (scan_last) idle_nx = 1'b1;
                else if (!image_rdy_i) pause_nx = 1'b1;
                else run_nx = 1'b1;
            end
            st_pause: begin
                if (image_rdy_i) run_nx = 1'b1;
                else pause_nx = 1'b1;
            end
            default: idle_nx = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st_idle  <= 1'b1;
            st_run   <= 1'b0;
            st_pause <= 1'b0;
        end else begin
            st_idle  <= idle_nx;
            st_run   <= run_nx;
            st_pause <= pause_nx;
        end
    end

    // depth first, then kernel width and height, then window origin
    always_ff @(posedge clk) begin
        if (rst | st_idle) begin
            area_w_cnt <= '0;
            area_h_cnt <= '0;
            kern_w_cnt <= '0;
            kern_h_cnt <= '0;
            kern_d_cnt <= '0;
        end else if (st_run) begin
            kern_d_cnt <= kern_d_cnt + 1'b1;
            if (kern_d_last) begin
                kern_d_cnt <= '0;
                kern_w_cnt <= kern_w_cnt + 1'b1;
                if (kern_w_last) begin
                    kern_w_cnt <= '0;
                    kern_h_cnt <= kern_h_cnt + 1'b1;
                    if (kern_h_last) kern_h_cnt <= '0;
                end
            end
            if (kern_last) begin
                area_w_cnt <= area_w_cnt + geom_i.conv_step;
                if (area_w_last) begin
                    area_w_cnt <= '0;
                    area_h_cnt <= area_h_cnt + geom_i.conv_step;
                    if (area_h_last) area_h_cnt <= '0;
                end
            end
        end
    end

    always_comb begin
        pos_o.pos_w = area_w_cnt + kern_w_cnt;
        pos_o.pos_h = area_h_cnt + kern_h_cnt;
        pos_o.pos_d = kern_d_cnt;
        pos_o.valid = st_run;
        pos_o.last  = st_run & scan_last;
    end

endmodule

// File: design/read_config.sv
`timescale 1ns/1ps

module read_config (
    input  logic                            clk,
    input  img_read_pkg::cfg_word_u         cfg_data_i,
    input  logic [img_read_pkg::CFG_AW-1:0] cfg_addr_i,
    input  logic                            cfg_valid_i,
    input  logic                            next_i,
    output img_read_pkg::geom_t             geom_o,
    output logic                            geom_ready_o
);
    import img_read_pkg::*;

    // values as written by the host, zero based
    logic [COORD_W-1:0] cfg_img_w;
    logic [15:0]        cfg_img_d;
    logic [15:0]        cfg_img_h;
    logic [7:0]         cfg_pad_l;
    logic [7:0]         cfg_pad_r;
    logic [7:0]         cfg_pad_t;
    logic [7:0]         cfg_pad_b;
    logic [7:0]         cfg_conv_side;
    logic [15:0]        cfg_conv_step;

    // loaded on next_i
    logic               load_1p;
    logic [COORD_W-1:0] img_w;
    logic [COORD_W-1:0] img_h;
    logic [COORD_W-1:0] img_d;
    logic [COORD_W-1:0] pad_l;
    logic [COORD_W-1:0] pad_r;
    logic [COORD_W-1:0] pad_t;
    logic [COORD_W-1:0] pad_b;
    logic [COORD_W-1:0] kern;
    logic [COORD_W-1:0] step;

    logic               load_2p;
    logic [COORD_W-1:0] area_w;
    logic [COORD_W-1:0] area_h;
    logic [COORD_W-1:0] edge_r;
    logic [COORD_W-1:0] edge_b;
    logic [LIN_W-1:0]   plane_wxd;

    always_ff @(posedge clk) begin
        if (cfg_valid_i) begin
            case (cfg_addr_i)
                CFG_IMG_W: cfg_img_w <= cfg_data_i.img_w[COORD_W-1:0];
                CFG_IMG_DH: begin
                    cfg_img_d <= cfg_data_i.dh.d;
                    cfg_img_h <= cfg_data_i.dh.h;
                end
                CFG_PAD: begin
                    cfg_pad_l <= cfg_data_i.pad.l;
                    cfg_pad_r <= cfg_data_i.pad.r;
                    cfg_pad_t <= cfg_data_i.pad.t;
                    cfg_pad_b <= cfg_data_i.pad.b;
                end
                CFG_CONV: begin
                    cfg_conv_side <= cfg_data_i.conv.side;
                    cfg_conv_step <= cfg_data_i.conv.step;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        load_1p <= next_i;
        if (next_i) begin
            img_w <= cfg_img_w + 1'b1;     // cfg 0 is a one pixel image
            img_h <= cfg_img_h + 1'b1;
            img_d <= cfg_img_d + 1'b1;
            pad_l <= COORD_W'(cfg_pad_l);  // cfg 0 is no padding
            pad_r <= COORD_W'(cfg_pad_r);
            pad_t <= COORD_W'(cfg_pad_t);
            pad_b <= COORD_W'(cfg_pad_b);
            kern  <= COORD_W'(cfg_conv_side) + 1'b1;
            step  <= cfg_conv_step + 1'b1;
        end
    end

    // padded area and the image edges inside it
    always_ff @(posedge clk) begin
        load_2p   <= load_1p;
        area_w    <= pad_l + img_w + pad_r;
        area_h    <= pad_t + img_h + pad_b;
        edge_r    <= pad_l + img_w - 1'b1;
        edge_b    <= pad_t + img_h - 1'b1;
        plane_wxd <= LIN_W'(img_w) * LIN_W'(img_d);
    end

    always_ff @(posedge clk) begin
        geom_ready_o      <= load_2p;
        geom_o.img_d      <= img_d;
        geom_o.conv_step  <= step;
        geom_o.kern_max   <= kern - 1'b1;
        geom_o.depth_max  <= img_d - 1'b1;
        geom_o.area_w_max <= area_w - kern;
        geom_o.area_h_max <= area_h - kern;
        geom_o.edge_l     <= pad_l;
        geom_o.edge_r     <= edge_r;
        geom_o.edge_t     <= pad_t;
        geom_o.edge_b     <= edge_b;
        geom_o.pad_l      <= pad_l;
        geom_o.pad_t      <= pad_t;
        geom_o.plane_wxd  <= plane_wxd;
    end

endmodule

// File: design/img_read_pkg.sv
package img_read_pkg;

    localparam int CFG_DW = 32;
    localparam int CFG_AW = 5;

    // config register map
    localparam logic [CFG_AW-1:0] CFG_IMG_W  = 5'd0;
    localparam logic [CFG_AW-1:0] CFG_IMG_DH = 5'd1;
    localparam logic [CFG_AW-1:0] CFG_PAD    = 5'd2;
    localparam logic [CFG_AW-1:0] CFG_CONV   = 5'd3;

    localparam int RD_LATENCY = 3;         // memory address to data, in cycles
    localparam int GROUP_NB   = 4;
    localparam int PIXEL_W    = 16;
    localparam int BUS_W      = GROUP_NB * PIXEL_W;
    localparam int MEM_AW     = 16;
    localparam int COORD_W    = 16;
    localparam int LIN_W      = 32;
    localparam int FIFO_AW    = 4;

    // one config word, read according to the address it was written to
    typedef union packed {
        logic [CFG_DW-1:0] img_w;
        struct packed {
            logic [15:0] d;
            logic [15:0] h;
        } dh;
        struct packed {
            logic [7:0] l;
            logic [7:0] r;
            logic [7:0] t;
            logic [7:0] b;
        } pad;
        struct packed {
            logic [7:0]  maxp;             // not decoded
            logic [7:0]  side;
            logic [15:0] step;
        } conv;
    } cfg_word_u;

    typedef struct packed {
        logic [COORD_W-1:0] img_d;
        logic [COORD_W-1:0] conv_step;
        logic [COORD_W-1:0] kern_max;
        logic [COORD_W-1:0] depth_max;
        logic [COORD_W-1:0] area_w_max;    // last origin a full window fits at
        logic [COORD_W-1:0] area_h_max;
        logic [COORD_W-1:0] edge_l;
        logic [COORD_W-1:0] edge_r;
        logic [COORD_W-1:0] edge_t;
        logic [COORD_W-1:0] edge_b;
        logic [COORD_W-1:0] pad_l;
        logic [COORD_W-1:0] pad_t;
        logic [LIN_W-1:0]   plane_wxd;
    } geom_t;

    typedef struct packed {
        logic [COORD_W-1:0] pos_w;
        logic [COORD_W-1:0] pos_h;
        logic [COORD_W-1:0] pos_d;
        logic               valid;
        logic               last;
    } scan_pos_t;

    typedef struct packed {
        logic read;
        logic pad;
        logic last;
    } beat_tag_t;

endpackage
